// File: list.f
+incdir+sim
source/sha256_pkg.sv
source/sha256_stage_if.sv
source/sha256_load_stage.sv
source/sha256_round_stage.sv
source/sha256_final_stage.sv
source/sha256_second_hash.sv
sim/tb_clock.sv
sim/tb_sha256_second_hash.sv

// File: run_sim.sh
#!/bin/sh
# Build and run, then judge the run from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module tb_sha256_second_hash -o tb_sim > sim.log 2>&1 &&
./obj_dir/tb_sim >> sim.log 2>&1 ||
echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	input  logic reset_req_i,
	output logic CLK,
	output logic RST
);

	localparam int HALF_PERIOD  = 50;
	localparam int RESET_CYCLES = 8;

	initial begin
		CLK = 1'b0;
		forever begin
			#(HALF_PERIOD);
			CLK = ~CLK;
		end
	end

	// Power-on reset, then an asynchronous reset for every request
	initial begin
		RST <= 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		RST <= 1'b1;
		forever begin
			@(posedge reset_req_i);
			#(HALF_PERIOD / 2);
			RST <= 1'b0;
			repeat (RESET_CYCLES) @(posedge CLK);
			RST <= 1'b1;
		end
	end

endmodule

// File: sim/sha256_model.svh
`ifndef SHA256_MODEL_SVH
`define SHA256_MODEL_SVH

localparam logic [31:0] MODEL_K [64] = '{
	32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
	32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
	32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
	32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
	32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
	32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
	32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
	32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
	32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
	32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
	32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
	32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
	32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
	32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
	32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
	32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
};

localparam logic [31:0] MODEL_H0 [8] = '{
	32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
	32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
};

function automatic logic [31:0] ror32(input logic [31:0] x, input int n);
	return (x >> n) | (x << (32 - n));
endfunction

// SHA-256 of a 32-byte message, so exactly one padded block
function automatic logic [255:0] sha256_block(input logic [255:0] msg);
	logic [31:0]  w [64];
	logic [31:0]  v [8];
	logic [31:0]  s0;
	logic [31:0]  s1;
	logic [31:0]  t1;
	logic [31:0]  t2;
	logic [255:0] result;
	for (int i = 0; i < 8; i++) begin
		w[i] = msg[255 - 32 * i -: 32];
	end
	w[8] = 32'h80000000;
	for (int i = 9; i < 15; i++) begin
		w[i] = 32'h0;
	end
	w[15] = 32'd256;
	for (int i = 16; i < 64; i++) begin
		s0 = ror32(w[i - 15], 7) ^ ror32(w[i - 15], 18) ^ (w[i - 15] >> 3);
		s1 = ror32(w[i - 2], 17) ^ ror32(w[i - 2], 19) ^ (w[i - 2] >> 10);
		w[i] = w[i - 16] + s0 + w[i - 7] + s1;
	end
	for (int i = 0; i < 8; i++) begin
		v[i] = MODEL_H0[i];
	end
	for (int i = 0; i < 64; i++) begin
		s1 = ror32(v[4], 6) ^ ror32(v[4], 11) ^ ror32(v[4], 25);
		t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + MODEL_K[i] + w[i];
		s0 = ror32(v[0], 2) ^ ror32(v[0], 13) ^ ror32(v[0], 22);
		t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
		v[7] = v[6];
		v[6] = v[5];
		v[5] = v[4];
		v[4] = v[3] + t1;
		v[3] = v[2];
		v[2] = v[1];
		v[1] = v[0];
		v[0] = t1 + t2;
	end
	for (int i = 0; i < 8; i++) begin
		result[255 - 32 * i -: 32] = v[i] + MODEL_H0[i];
	end
	return result;
endfunction

`endif

// File: sim/tb_sha256_second_hash.sv
`timescale 1ns/1ps

module tb_sha256_second_hash;

	localparam int PIPE_DEPTH       = 66;
	localparam int TIMEOUT_CYCLES   = 3000;
	localparam int MIN_VALID_CHECKS = 500;

	// SHA-256 of "abc" and the SHA-256 of that digest
	localparam logic [255:0] KAT_BLOCK =
		256'hba7816bf8f01cfea414140de5dae2223b00361a396177a9cb410ff61f20015ad;
	localparam logic [255:0] KAT_DIGEST =
		256'h4f8b42c22dd3729b519ba6f68d2da7cc5b2d606d05daed5ad5128cc03e6c6358;

	logic         CLK;
	logic         RST;
	logic         reset_req;
	logic         write_en;
	logic [255:0] block;
	logic [255:0] digest;
	logic         valid;

	int           seed = 32'h71fe6536;
	int           cycle_count = 0;
	int           adv_count;
	int           valid_checks = 0;
	int           kat_checks = 0;
	logic [255:0] exp_digest;
	logic         exp_valid;
	logic         kat_due;
	logic [255:0] prev_digest;
	logic         prev_valid;
	logic         prev_wen;
	logic         prev_rst;
	logic [255:0] digest_q [$];
	logic         kat_flag_q [$];

	`include "sha256_model.svh"

	tb_clock u_clock (
		.reset_req_i (reset_req),
		.CLK         (CLK),
		.RST         (RST)
	);

	sha256_second_hash DUT (
		.CLK        (CLK),
		.RST        (RST),
		.write_en_i (write_en),
		.block_i    (block),
		.digest_o   (digest),
		.valid_o    (valid)
	);

	task automatic report_mismatch(input string what, input logic [255:0] expected,
		input logic [255:0] actual);
		$display("ERROR at %0t: %s expected %h, got %h", $time, what, expected, actual);
		$display("Simulation failed");
		$fatal(1, "%s check failed", what);
	endtask

	task automatic report_flag_mismatch(input string what, input logic expected,
		input logic actual);
		$display("ERROR at %0t: %s expected %b, got %b", $time, what, expected, actual);
		$display("Simulation failed");
		$fatal(1, "%s check failed", what);
	endtask

	function automatic logic [255:0] random_block();
		logic [255:0] b;
		for (int i = 0; i < 8; i++) begin
			b[32 * i +: 32] = $random(seed);
		end
		return b;
	endfunction

	// Expected outputs, paired with blocks by advance count
	always @(posedge CLK or negedge RST) begin : scoreboard
		logic kat_flag;
		if (!RST) begin
			adv_count  <= 0;
			exp_digest <= '0;
			exp_valid  <= 1'b0;
			kat_due    <= 1'b0;
			digest_q.delete();
			kat_flag_q.delete();
		end else if (write_en) begin
			adv_count <= adv_count + 1;
			digest_q.push_back(sha256_block(block));
			kat_flag_q.push_back(block == KAT_BLOCK);
			if (adv_count + 1 >= PIPE_DEPTH) begin
				kat_flag = kat_flag_q.pop_front();
				exp_digest   <= digest_q.pop_front();
				exp_valid    <= 1'b1;
				kat_due      <= kat_flag;
				valid_checks <= valid_checks + 1;
				if (kat_flag) begin
					kat_checks <= kat_checks + 1;
				end
			end else begin
				exp_digest <= '0;
				exp_valid  <= 1'b0;
				kat_due    <= 1'b0;
			end
		end
	end

	always @(posedge CLK) begin
		prev_digest <= digest;
		prev_valid  <= valid;
		prev_wen    <= write_en;
		prev_rst    <= RST;
	end

	digest_check: assert property (@(posedge CLK) cycle_count < 1 || digest == exp_digest)
		else report_mismatch("digest_o", $sampled(exp_digest), $sampled(digest));

	valid_check: assert property (@(posedge CLK) cycle_count < 1 || valid == exp_valid)
		else report_flag_mismatch("valid_o", $sampled(exp_valid), $sampled(valid));

	known_answer_check: assert property (@(posedge CLK) !kat_due || digest == KAT_DIGEST)
		else report_mismatch("known-answer digest", KAT_DIGEST, $sampled(digest));

	// No advance on the previous edge means the outputs held
	stall_hold_check: assert property (@(posedge CLK)
		cycle_count < 2 || !RST || !prev_rst || prev_wen
		|| (digest == prev_digest && valid == prev_valid))
		else report_mismatch("held digest_o", $sampled(prev_digest), $sampled(digest));

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Run stopped after %0d cycles before the test sequence ended", cycle_count);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge CLK);
			write_en <= 1'b0;
		end
	endtask

	task automatic drive_known_answer();
		@(posedge CLK);
		write_en <= 1'b1;
		block    <= KAT_BLOCK;
	endtask

	task automatic stream_blocks(input int n, input int en_percent);
		repeat (n) begin
			@(posedge CLK);
			write_en <= ($unsigned($random(seed)) % 100) < en_percent;
			block    <= random_block();
		end
	endtask

	task automatic restart_pipeline();
		@(posedge CLK);
		write_en  <= 1'b0;
		reset_req <= 1'b1;
		@(posedge CLK);
		reset_req <= 1'b0;
		wait (RST);
	endtask

	initial begin
		write_en  <= 1'b0;
		block     <= '0;
		reset_req <= 1'b0;
		wait (RST);
		idle(3);
		drive_known_answer();
		stream_blocks(100, 100);
		stream_blocks(300, 100);
		stream_blocks(600, 50);
		stream_blocks(20, 100);
		restart_pipeline();
		stream_blocks(150, 100);
		idle(3);
		if (kat_checks == 1 && valid_checks >= MIN_VALID_CHECKS) begin
			$display("Simulation passed");
			$finish;
		end else begin
			$display("Too few outputs were compared: %0d digests, %0d known-answer",
				valid_checks, kat_checks);
			$display("Simulation failed");
			$fatal(1, "incomplete run");
		end
	end

endmodule

// File: source/sha256_final_stage.sv
`timescale 1ns/1ps

module sha256_final_stage
	import sha256_pkg::*;
(
	input  logic        CLK,
	input  logic        RST,
	input  logic        write_en_i,
	sha256_stage_if.dst in_if,
	output digest_t     digest_o,
	output logic        valid_o
);

	logic [FILL_W-1:0] fill_q;
	digest_t           sum;
	digest_t           digest_q;
	logic              valid_q;

	// Feed-forward of the initial hash value
	always_comb begin
		for (int i = 0; i < DIGEST_WORDS; i++) begin
			sum[i * WORD_W +: WORD_W] = in_if.state[i * WORD_W +: WORD_W]
				+ H_INIT[i * WORD_W +: WORD_W];
		end
	end

	// The first real block arrives on the advance that takes the count to PIPE_DEPTH
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			fill_q   <= '0;
			digest_q <= '0;
			valid_q  <= 1'b0;
		end else if (write_en_i) begin
			if (fill_q >= FILL_W'(PIPE_DEPTH - 1)) begin
				fill_q   <= FILL_W'(PIPE_DEPTH);
				digest_q <= sum;
				valid_q  <= 1'b1;
			end else begin
				fill_q   <= fill_q + 1'b1;
				digest_q <= '0;
				valid_q  <= 1'b0;
			end
		end
	end

	assign digest_o = digest_q;
	assign valid_o  = valid_q;

endmodule

// File: source/sha256_load_stage.sv
`timescale 1ns/1ps

module sha256_load_stage
	import sha256_pkg::*;
(
	input  logic        CLK,
	input  logic        RST,
	input  logic        write_en_i,
	input  digest_t     block_i,
	sha256_stage_if.src out_if
);

	sched_window_t window_d;
	sched_window_t window_q;
	work_state_t   state_q;

	// Digest words first, most significant word leading, then the padding
	always_comb begin
		for (int i = 0; i < DIGEST_WORDS; i++) begin
			window_d[i]                = block_i[DIGEST_W - 1 - i * WORD_W -: WORD_W];
			window_d[DIGEST_WORDS + i] = PAD_WORDS[i];
		end
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			state_q  <= '0;
			window_q <= '{default: '0};
		end else if (write_en_i) begin
			state_q  <= H_INIT;
			window_q <= window_d;
		end
	end

	assign out_if.state  = state_q;
	assign out_if.window = window_q;

endmodule

// File: source/sha256_pkg.sv
package sha256_pkg;

	localparam int WORD_W       = 32;
	localparam int DIGEST_W     = 256;
	localparam int DIGEST_WORDS = DIGEST_W / WORD_W;
	localparam int NUM_ROUNDS   = 64;
	localparam int SCHED_WORDS  = 16;

	// Rounds that still need a new word appended to the window
	localparam int SCHED_ROUNDS = NUM_ROUNDS - SCHED_WORDS;

	// Load stage, one register per round, output register
	localparam int PIPE_DEPTH = 1 + NUM_ROUNDS + 1;
	localparam int FILL_W     = $clog2(PIPE_DEPTH + 1);

	typedef logic [WORD_W-1:0]   word_t;
	typedef logic [DIGEST_W-1:0] digest_t;

	typedef struct packed {
		word_t a;
		word_t b;
		word_t c;
		word_t d;
		word_t e;
		word_t f;
		word_t g;
		word_t h;
	} work_state_t;

	// Entry 0 is the word consumed by the current round
	typedef word_t sched_window_t [SCHED_WORDS];

	localparam word_t ROUND_K [NUM_ROUNDS] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	localparam work_state_t H_INIT = '{
		a: 32'h6a09e667,
		b: 32'hbb67ae85,
		c: 32'h3c6ef372,
		d: 32'ha54ff53a,
		e: 32'h510e527f,
		f: 32'h9b05688c,
		g: 32'h1f83d9ab,
		h: 32'h5be0cd19
	};

	// Second half of the block for a 256-bit message
	localparam word_t PAD_WORDS [DIGEST_WORDS] = '{
		32'h80000000,
		32'h00000000,
		32'h00000000,
		32'h00000000,
		32'h00000000,
		32'h00000000,
		32'h00000000,
		32'h00000100
	};

	function automatic word_t rotr(word_t x, int unsigned n);
		return (x >> n) | (x << (WORD_W - n));
	endfunction

	function automatic word_t big_sigma0(word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t big_sigma1(word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic word_t small_sigma0(word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t small_sigma1(word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	function automatic word_t choose(word_t x, word_t y, word_t z);
		return (x & y) ^ (~x & z);
	endfunction

	function automatic word_t majority(word_t x, word_t y, word_t z);
		return (x & y) ^ (x & z) ^ (y & z);
	endfunction

endpackage

// File: source/sha256_round_stage.sv
`timescale 1ns/1ps

module sha256_round_stage
	import sha256_pkg::*;
#(
	parameter int ROUND = 0
) (
	input  logic        CLK,
	input  logic        RST,
	input  logic        write_en_i,
	sha256_stage_if.dst in_if,
	sha256_stage_if.src out_if
);

	work_state_t   s;
	work_state_t   state_d;
	work_state_t   state_q;
	word_t         t1;
	word_t         t2;
	word_t         w_next;
	sched_window_t window_d;
	sched_window_t window_q;

	// Compression round
	always_comb begin
		s  = in_if.state;
		t1 = s.h + big_sigma1(s.e) + choose(s.e, s.f, s.g)
			+ ROUND_K[ROUND] + in_if.window[0];
		t2 = big_sigma0(s.a) + majority(s.a, s.b, s.c);

		state_d.a = t1 + t2;
		state_d.b = s.a;
		state_d.c = s.b;
		state_d.d = s.c;
		state_d.e = s.d + t1;
		state_d.f = s.e;
		state_d.g = s.f;
		state_d.h = s.g;
	end

	// Expanded word W[ROUND+16]
	if (ROUND < SCHED_ROUNDS) begin : g_expand
		assign w_next = small_sigma1(in_if.window[14]) + in_if.window[9]
			+ small_sigma0(in_if.window[1]) + in_if.window[0];
	end else begin : g_tail
		// Nothing downstream reads these slots
		assign w_next = '0;
	end

	always_comb begin
		for (int i = 0; i < SCHED_WORDS - 1; i++) begin
			window_d[i] = in_if.window[i + 1];
		end
		window_d[SCHED_WORDS - 1] = w_next;
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			state_q  <= '0;
			window_q <= '{default: '0};
		end else if (write_en_i) begin
			state_q  <= state_d;
			window_q <= window_d;
		end
	end

	assign out_if.state  = state_q;
	assign out_if.window = window_q;

endmodule

// File: source/sha256_second_hash.sv
`timescale 1ns/1ps

module sha256_second_hash
	import sha256_pkg::*;
(
	input  logic                CLK,
	input  logic                RST,
	input  logic                write_en_i,
	input  logic [DIGEST_W-1:0] block_i,
	output logic [DIGEST_W-1:0] digest_o,
	output logic                valid_o
);

	// Link n feeds round n, the last link feeds the output stage
	sha256_stage_if stage_if [NUM_ROUNDS + 1] ();

	sha256_load_stage u_load (
		.CLK        (CLK),
		.RST        (RST),
		.write_en_i (write_en_i),
		.block_i    (block_i),
		.out_if     (stage_if[0])
	);

	for (genvar r = 0; r < NUM_ROUNDS; r++) begin : g_round
		sha256_round_stage #(
			.ROUND (r)
		) u_round (
			.CLK        (CLK),
			.RST        (RST),
			.write_en_i (write_en_i),
			.in_if      (stage_if[r]),
			.out_if     (stage_if[r + 1])
		);
	end

	sha256_final_stage u_final (
		.CLK        (CLK),
		.RST        (RST),
		.write_en_i (write_en_i),
		.in_if      (stage_if[NUM_ROUNDS]),
		.digest_o   (digest_o),
		.valid_o    (valid_o)
	);

endmodule

// File: source/sha256_stage_if.sv
`timescale 1ns/1ps

interface sha256_stage_if
	import sha256_pkg::*;
();

	// Working variables a to h after the producing stage
	work_state_t   state;

	// Message schedule still ahead of the next round
	sched_window_t window;

	modport src (
		output state,
		output window
	);

	modport dst (
		input state,
		input window
	);

endinterface
